//--- common/iss_consts.svh
`ifndef ISS_CONSTS_SVH
`define ISS_CONSTS_SVH

// Register and data width
`define ISS_XLEN 64

// Integer register count, x0 included
`define ISS_NUM_REG 32

// Word address bits of the unified memory, 32-bit words
`define ISS_MEM_AW 12

// Boot address, maps to word 0
`define ISS_RESET_PC 64'h0000_0000_8000_0000

// Host mailbox byte address, words 0x400 and 0x401
`define ISS_TOHOST_ADDR 32'h8000_1000

`endif

//--- common/iss_pkg.sv
`include "iss_consts.svh"

package iss_pkg;

	typedef logic [`ISS_XLEN-1:0] xdata_t;

	// RV64I major opcodes kept by the core
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_BRANCH = 7'b1100011,
		OP_STORE  = 7'b0100011,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B,	// LUI
		ALU_LINK,	// JAL return address
		ALU_AUIPC
	} alu_op_e;

	typedef struct packed {
		opcode_e	opcode;
		alu_op_e	alu_op;
		logic [2:0]	funct3;
		logic [4:0]	rd;
		logic [4:0]	rs1;
		logic [4:0]	rs2;
		logic		use_imm;
		xdata_t		imm;	// Sign-extended
		logic		wr_en;
		logic		is_branch;
		logic		is_jal;
		logic		is_store;
	} decoded_t;

	typedef struct packed {
		logic			valid;
		logic [`ISS_MEM_AW-1:0]	addr;	// Word index
		logic [31:0]		data;
	} prog_wr_t;

	typedef struct packed {
		logic			valid;
		logic [`ISS_MEM_AW+1:0]	addr;	// Byte address
		xdata_t			data;
	} store_t;

endpackage

//--- core/iss_decode.sv
`timescale 1ns/10ps
`include "iss_consts.svh"

module iss_decode
	import iss_pkg::*;
(
	input  logic [31:0]	inst_i,
	output decoded_t	dec_o
);

	opcode_e	op;
	logic [2:0]	funct3;
	logic [6:0]	funct7;
	logic		writes;	// Legal encoding with a register result
	xdata_t		imm_i;
	xdata_t		imm_s;
	xdata_t		imm_b;
	xdata_t		imm_u;
	xdata_t		imm_j;

	assign op     = opcode_e'(inst_i[6:0]);
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	assign imm_i = {{(`ISS_XLEN-12){inst_i[31]}}, inst_i[31:20]};
	assign imm_s = {{(`ISS_XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
	assign imm_b = {{(`ISS_XLEN-12){inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_u = {{(`ISS_XLEN-32){inst_i[31]}}, inst_i[31:12], 12'h000};
	assign imm_j = {{(`ISS_XLEN-20){inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

	// Shared funct3 map of OP and OP-IMM, alt is instruction bit 30
	function automatic alu_op_e f3_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return alt ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	always_comb begin
		dec_o        = '0;
		dec_o.opcode = op;
		dec_o.alu_op = ALU_ADD;
		dec_o.funct3 = funct3;
		dec_o.rd     = inst_i[11:7];
		dec_o.rs1    = inst_i[19:15];
		dec_o.rs2    = inst_i[24:20];
		writes       = 1'b0;

		case (op)
			OP_LUI: begin
				writes        = 1'b1;
				dec_o.alu_op  = ALU_PASS_B;
				dec_o.use_imm = 1'b1;
				dec_o.imm     = imm_u;
			end
			OP_AUIPC: begin
				writes       = 1'b1;
				dec_o.alu_op = ALU_AUIPC;
				dec_o.imm    = imm_u;
			end
			OP_JAL: begin
				writes       = 1'b1;
				dec_o.alu_op = ALU_LINK;
				dec_o.imm    = imm_j;
				dec_o.is_jal = 1'b1;
			end
			OP_BRANCH: begin
				dec_o.imm       = imm_b;
				dec_o.is_branch = (funct3[2:1] != 2'b01);	// 010 and 011 reserved
			end
			OP_STORE: begin
				dec_o.imm      = imm_s;
				dec_o.is_store = (funct3 == 3'b011);	// SD only
			end
			OP_IMM: begin
				dec_o.use_imm = 1'b1;
				dec_o.imm     = imm_i;
				dec_o.alu_op  = f3_op(funct3, (funct3 == 3'b101) && inst_i[30]);
				case (funct3)
					3'b001:  writes = (funct7[6:1] == 6'b000000);
					3'b101:  writes = (funct7[6:1] == 6'b000000) || (funct7[6:1] == 6'b010000);
					default: writes = 1'b1;
				endcase
			end
			OP_REG: begin
				dec_o.alu_op = f3_op(funct3, inst_i[30]);
				writes       = (funct7 == 7'b0000000) ||
					       ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
			end
			default: ;	// Unknown encoding retires as a no-op
		endcase

		dec_o.wr_en = writes && (dec_o.rd != 5'd0);
	end

endmodule

//--- core/iss_alu.sv
`timescale 1ns/10ps
`include "iss_consts.svh"

module iss_alu
	import iss_pkg::*;
(
	input  decoded_t	dec_i,
	input  xdata_t		pc_i,
	input  xdata_t		rs1_d_i,
	input  xdata_t		rs2_d_i,
	output xdata_t		result_o
);

	xdata_t		op_b;
	logic [5:0]	shamt;
	logic		lt_s;
	logic		lt_u;

	assign op_b  = dec_i.use_imm ? dec_i.imm : rs2_d_i;
	assign shamt = op_b[5:0];	// RV64 shifts take 6 bits

	assign lt_s = $signed(rs1_d_i) < $signed(op_b);
	assign lt_u = rs1_d_i < op_b;

	always_comb begin
		case (dec_i.alu_op)
			ALU_ADD:    result_o = rs1_d_i + op_b;
			ALU_SUB:    result_o = rs1_d_i - op_b;
			ALU_SLL:    result_o = rs1_d_i << shamt;
			ALU_SLT:    result_o = {{(`ISS_XLEN-1){1'b0}}, lt_s};
			ALU_SLTU:   result_o = {{(`ISS_XLEN-1){1'b0}}, lt_u};
			ALU_XOR:    result_o = rs1_d_i ^ op_b;
			ALU_SRL:    result_o = rs1_d_i >> shamt;
			ALU_SRA:    result_o = $signed(rs1_d_i) >>> shamt;
			ALU_OR:     result_o = rs1_d_i | op_b;
			ALU_AND:    result_o = rs1_d_i & op_b;
			ALU_PASS_B: result_o = op_b;
			ALU_LINK:   result_o = pc_i + `ISS_XLEN'd4;
			ALU_AUIPC:  result_o = pc_i + dec_i.imm;
			default:    result_o = '0;
		endcase
	end

endmodule

//--- core/iss_next_pc.sv
`timescale 1ns/10ps
`include "iss_consts.svh"

module iss_next_pc
	import iss_pkg::*;
(
	input  decoded_t	dec_i,
	input  xdata_t		pc_i,
	input  xdata_t		rs1_d_i,
	input  xdata_t		rs2_d_i,
	output xdata_t		next_pc_o
);

	logic	eq;
	logic	lt;
	logic	ltu;
	logic	cond;
	xdata_t	target;

	assign eq  = rs1_d_i == rs2_d_i;
	assign lt  = $signed(rs1_d_i) < $signed(rs2_d_i);
	assign ltu = rs1_d_i < rs2_d_i;

	always_comb begin
		case (dec_i.funct3)
			3'b000:  cond = eq;	// BEQ
			3'b001:  cond = !eq;	// BNE
			3'b100:  cond = lt;	// BLT
			3'b101:  cond = !lt;	// BGE
			3'b110:  cond = ltu;	// BLTU
			3'b111:  cond = !ltu;	// BGEU
			default: cond = 1'b0;
		endcase
	end

	assign target = pc_i + dec_i.imm;

	assign next_pc_o = (dec_i.is_jal || (dec_i.is_branch && cond)) ? target
								      : pc_i + `ISS_XLEN'd4;

endmodule

//--- core/iss_core.sv
`timescale 1ns/10ps
`include "iss_consts.svh"

module iss_core
	import iss_pkg::*;
(
	input  logic		CLK,
	input  logic		RSTn,
	input  logic		run_i,

	input  logic [31:0]	inst_i,
	output xdata_t		pc_o,
	output store_t		store_o
);

	xdata_t		pc;
	xdata_t		next_pc;
	xdata_t		rs1_d;
	xdata_t		rs2_d;
	xdata_t		alu_result;
	xdata_t		st_addr;
	decoded_t	dec;

	xdata_t		regs [`ISS_NUM_REG];

	iss_decode decode_inst (
		.inst_i		(inst_i),
		.dec_o		(dec)
	);

	iss_alu alu_inst (
		.dec_i		(dec),
		.pc_i		(pc),
		.rs1_d_i	(rs1_d),
		.rs2_d_i	(rs2_d),
		.result_o	(alu_result)
	);

	iss_next_pc next_pc_inst (
		.dec_i		(dec),
		.pc_i		(pc),
		.rs1_d_i	(rs1_d),
		.rs2_d_i	(rs2_d),
		.next_pc_o	(next_pc)
	);

	// x0 is hardwired
	assign rs1_d = (dec.rs1 == 5'd0) ? '0 : regs[dec.rs1];
	assign rs2_d = (dec.rs2 == 5'd0) ? '0 : regs[dec.rs2];

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			pc <= `ISS_RESET_PC;
		end else if (run_i) begin
			pc <= next_pc;
		end
	end

	always_ff @(posedge CLK) begin
		if (run_i && dec.wr_en) begin
			regs[dec.rd] <= alu_result;	// wr_en already excludes x0
		end
	end

	// SD goes out in the same cycle and lands at the retiring edge
	assign st_addr       = rs1_d + dec.imm;
	assign store_o.valid = run_i && dec.is_store;
	assign store_o.addr  = st_addr[`ISS_MEM_AW+1:0];
	assign store_o.data  = rs2_d;

	assign pc_o = pc;

endmodule

//--- rtl/iss_mem.sv
`timescale 1ns/10ps
`include "iss_consts.svh"

module iss_mem
	import iss_pkg::*;
(
	input  logic		CLK,
	input  logic		RSTn,

	input  xdata_t		pc_i,
	output logic [31:0]	inst_o,

	input  store_t		store_i,
	input  prog_wr_t	prog_i,

	output logic		tohost_we_o,
	output xdata_t		tohost_o
);

	localparam logic [31:0] TOHOST_ADDR = `ISS_TOHOST_ADDR;
	localparam logic [`ISS_MEM_AW-1:0] TOHOST_LO = TOHOST_ADDR[`ISS_MEM_AW+1:2];
	localparam logic [`ISS_MEM_AW-1:0] TOHOST_HI = TOHOST_LO + 1'b1;

	logic [31:0]		mem [2**`ISS_MEM_AW];
	logic [`ISS_MEM_AW-1:0]	st_lo;
	logic [`ISS_MEM_AW-1:0]	st_hi;
	logic			st_tohost;

	assign st_lo = store_i.addr[`ISS_MEM_AW+1:2];
	assign st_hi = st_lo + 1'b1;

	assign inst_o = mem[pc_i[`ISS_MEM_AW+1:2]];	// Async fetch

	assign tohost_o = {mem[TOHOST_HI], mem[TOHOST_LO]};

	assign st_tohost = store_i.valid && (store_i.addr == TOHOST_ADDR[`ISS_MEM_AW+1:0]);

	// A core store takes the port over a program load
	always_ff @(posedge CLK) begin
		if (store_i.valid) begin
			mem[st_lo] <= store_i.data[31:0];
			mem[st_hi] <= store_i.data[63:32];
		end else if (prog_i.valid) begin
			mem[prog_i.addr] <= prog_i.data;
		end
	end

	// One-cycle strobe, new doubleword already visible
	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			tohost_we_o <= 1'b0;
		end else begin
			tohost_we_o <= st_tohost;
		end
	end

endmodule

//--- rtl/iss_top.sv
`timescale 1ns/10ps

module iss_top
	import iss_pkg::*;
(
	input  logic		CLK,
	input  logic		RSTn,

	input  prog_wr_t	prog_i,
	input  logic		run_i,

	output logic		tohost_we_o,
	output xdata_t		tohost_o
);

	xdata_t		pc;
	logic [31:0]	inst;
	store_t		store;

	iss_core core_inst (
		.CLK		(CLK),
		.RSTn		(RSTn),
		.run_i		(run_i),
		.inst_i		(inst),
		.pc_o		(pc),
		.store_o	(store)
	);

	// Shared instruction and data memory
	iss_mem mem_inst (
		.CLK		(CLK),
		.RSTn		(RSTn),
		.pc_i		(pc),
		.inst_o		(inst),
		.store_i	(store),
		.prog_i		(prog_i),
		.tohost_we_o	(tohost_we_o),
		.tohost_o	(tohost_o)
	);

endmodule

//--- verif/tb_iss_programs.svh
`ifndef TB_ISS_PROGRAMS_SVH
`define TB_ISS_PROGRAMS_SVH

localparam int NUM_PROGS = 10;
localparam int MAX_WORDS = 16;
localparam logic [6:0] OPC_IMM = 7'b0010011;
localparam logic [6:0] OPC_REG = 7'b0110011;
localparam logic [6:0] OPC_LUI = 7'b0110111;
localparam logic [6:0] OPC_AUIPC = 7'b0010111;

logic [31:0]	prog_words [NUM_PROGS][MAX_WORDS];
int		prog_len [NUM_PROGS];
logic [63:0]	prog_exp [NUM_PROGS];
logic [63:0]	prog_mask [NUM_PROGS];	// Bits of the mailbox that are checked
int		prog_count;
logic [31:0]	body [$];

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, OPC_REG};
endfunction

function automatic logic [31:0] i_type(input int imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd);
	logic [11:0] im;
	im = imm[11:0];
	return {im, rs1, f3, rd, OPC_IMM};
endfunction

function automatic logic [31:0] b_type(input int off, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [2:0] f3);
	logic [12:0] o;
	o = off[12:0];
	return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], 7'b1100011};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
	return {imm, rd, op};
endfunction

function automatic logic [31:0] j_type(input int off, input logic [4:0] rd);
	logic [20:0] o;
	o = off[20:0];
	return {o[20], o[10:1], o[11], o[19:12], rd, 7'b1101111};
endfunction

function automatic logic [31:0] sd_word(input logic [4:0] rs2, input logic [4:0] rs1,
		input int off);
	logic [11:0] o;
	o = off[11:0];
	return {o[11:5], rs2, rs1, 3'b011, o[4:0], 7'b0100011};
endfunction

// Appends the mailbox store and the final self loop, then files the entry
task automatic close_program(input logic [63:0] exp, input logic [63:0] mask);
	body.push_back(u_type(20'h80001, 6, OPC_LUI));	// x6 = sign-extended 0x80001000
	body.push_back(i_type(-1, 0, 3'b000, 7));
	body.push_back(i_type(32, 7, 3'b001, 7));	// x7 = upper ones
	body.push_back(r_type(7'b0000000, 7, 6, 3'b100, 6));
	body.push_back(sd_word(5, 6, 0));
	body.push_back(j_type(0, 0));
	prog_len[prog_count] = body.size();
	foreach (body[i]) prog_words[prog_count][i] = body[i];
	prog_exp[prog_count] = exp;
	prog_mask[prog_count] = mask;
	prog_count++;
	body.delete();
endtask

task automatic build_programs();
	longint		a;
	longint		b;
	logic [11:0]	r1;
	logic [11:0]	r2;
	logic [63:0]	x1;
	logic [63:0]	x2;

	prog_count = 0;
	// Register-register arithmetic
	a = -100;
	b = -7;
	body.push_back(i_type(-100, 0, 3'b000, 1));
	body.push_back(i_type(-7, 0, 3'b000, 2));
	body.push_back(r_type(7'b0100000, 2, 1, 3'b000, 3));
	body.push_back(r_type(7'b0000000, 2, 1, 3'b000, 4));
	body.push_back(r_type(7'b0000000, 4, 3, 3'b100, 5));
	body.push_back(r_type(7'b0000000, 2, 1, 3'b111, 3));
	body.push_back(r_type(7'b0000000, 3, 5, 3'b110, 5));
	close_program(((a - b) ^ (a + b)) | (a & b), '1);

	// Signed compares, -5 against 3
	body.push_back(i_type(-5, 0, 3'b000, 1));
	body.push_back(i_type(3, 0, 3'b000, 2));
	body.push_back(r_type(7'b0000000, 2, 1, 3'b010, 3));
	body.push_back(i_type(3, 1, 3'b010, 4));
	body.push_back(i_type(1, 3, 3'b001, 3));
	body.push_back(r_type(7'b0000000, 4, 3, 3'b110, 5));
	close_program(64'h3, '1);

	// Unsigned compares, plus the reversed SLTU that must be 1
	body.push_back(i_type(-5, 0, 3'b000, 1));
	body.push_back(i_type(3, 0, 3'b000, 2));
	body.push_back(r_type(7'b0000000, 2, 1, 3'b011, 3));
	body.push_back(i_type(3, 1, 3'b011, 4));
	body.push_back(r_type(7'b0000000, 1, 2, 3'b011, 8));
	body.push_back(i_type(2, 3, 3'b001, 3));
	body.push_back(i_type(1, 4, 3'b001, 4));
	body.push_back(r_type(7'b0000000, 4, 3, 3'b110, 5));
	body.push_back(r_type(7'b0000000, 8, 5, 3'b110, 5));
	close_program(64'h1, '1);

	// Shifts by 63 and right shifts of the sign bit
	body.push_back(i_type(1, 0, 3'b000, 1));
	body.push_back(i_type(63, 1, 3'b001, 2));
	body.push_back(i_type(63, 0, 3'b000, 3));
	body.push_back(r_type(7'b0000000, 3, 1, 3'b001, 4));
	body.push_back(i_type(60, 4, 3'b101, 9));
	body.push_back(i_type(32'h404, 4, 3'b101, 10));	// SRAI by 4
	body.push_back(r_type(7'b0000000, 9, 2, 3'b100, 5));
	body.push_back(r_type(7'b0000000, 10, 5, 3'b100, 5));
	close_program(64'h8000_0000_0000_0000 ^ 64'h8 ^ 64'hF800_0000_0000_0000, '1);

	// AUIPC at offsets 0 and 8, LUI with bit 31 set
	body.push_back(u_type(20'h00012, 1, OPC_AUIPC));
	body.push_back(u_type(20'h80000, 2, OPC_LUI));
	body.push_back(u_type(20'h00000, 3, OPC_AUIPC));
	body.push_back(r_type(7'b0100000, 3, 1, 3'b000, 4));
	body.push_back(r_type(7'b0000000, 2, 4, 3'b100, 5));
	close_program(((`ISS_RESET_PC + 64'h12000) - (`ISS_RESET_PC + 64'd8)) ^
		64'hFFFF_FFFF_8000_0000, '1);

	// BEQ, BNE, BLT taken
	body.push_back(i_type(-2, 0, 3'b000, 1));
	body.push_back(i_type(3, 0, 3'b000, 2));
	body.push_back(i_type(-2, 0, 3'b000, 3));
	body.push_back(i_type(64, 0, 3'b000, 5));
	body.push_back(b_type(8, 1, 3, 3'b000));
	body.push_back(i_type(1, 5, 3'b000, 5));
	body.push_back(b_type(8, 1, 2, 3'b001));
	body.push_back(i_type(2, 5, 3'b000, 5));
	body.push_back(b_type(8, 1, 2, 3'b100));
	body.push_back(i_type(4, 5, 3'b000, 5));
	close_program(64'd64, '1);

	// BGE, BLTU, BGEU taken, BGEU on equal operands
	body.push_back(i_type(-2, 0, 3'b000, 1));
	body.push_back(i_type(3, 0, 3'b000, 2));
	body.push_back(i_type(-2, 0, 3'b000, 3));
	body.push_back(i_type(64, 0, 3'b000, 5));
	body.push_back(b_type(8, 2, 1, 3'b101));
	body.push_back(i_type(1, 5, 3'b000, 5));
	body.push_back(b_type(8, 2, 1, 3'b110));
	body.push_back(i_type(2, 5, 3'b000, 5));
	body.push_back(b_type(8, 1, 3, 3'b111));
	body.push_back(i_type(4, 5, 3'b000, 5));
	close_program(64'd64, '1);

	// All six not taken, a wrong decision lands on the final loop
	body.push_back(i_type(-2, 0, 3'b000, 1));
	body.push_back(i_type(3, 0, 3'b000, 2));
	body.push_back(i_type(-2, 0, 3'b000, 3));
	body.push_back(i_type(100, 0, 3'b000, 5));
	body.push_back(b_type((15 - 4) * 4, 1, 2, 3'b000));
	body.push_back(b_type((15 - 5) * 4, 1, 3, 3'b001));
	body.push_back(b_type((15 - 6) * 4, 2, 1, 3'b100));
	body.push_back(b_type((15 - 7) * 4, 1, 2, 3'b101));
	body.push_back(b_type((15 - 8) * 4, 1, 2, 3'b110));	// -2 is huge unsigned
	body.push_back(b_type((15 - 9) * 4, 2, 1, 3'b111));
	close_program(64'd100, '1);

	// x0 write, unknown word, JAL link into x5
	body.push_back(i_type(5, 0, 3'b000, 0));
	body.push_back(32'hFFFF_FFFF);
	body.push_back(j_type(8, 5));
	body.push_back(i_type(0, 0, 3'b000, 5));
	body.push_back(r_type(7'b0000000, 0, 5, 3'b000, 5));
	close_program(`ISS_RESET_PC + 64'd12, 64'hFFFF_FFFF);

	// Random ADDI, ADD and XOR chain
	r1 = 12'($urandom);
	r2 = 12'($urandom);
	x1 = {{52{r1[11]}}, r1};
	x2 = {{52{r2[11]}}, r2};
	body.push_back(i_type(int'(r1), 0, 3'b000, 1));
	body.push_back(i_type(int'(r2), 0, 3'b000, 2));
	body.push_back(r_type(7'b0000000, 2, 1, 3'b000, 3));
	body.push_back(r_type(7'b0000000, 1, 3, 3'b100, 5));
	close_program((x1 + x2) ^ x1, '1);
endtask

`endif

//--- verif/tb_iss.sv
`timescale 1ns/10ps
`include "iss_consts.svh"

module tb_iss
	import iss_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 200;

	logic		CLK;
	logic		RSTn;
	prog_wr_t	prog;
	logic		run;
	logic		tohost_we;
	xdata_t		tohost;
	int		errors;
	int		checks;

	`include "tb_iss_programs.svh"

	iss_top iss_top_inst (
		.CLK		(CLK),
		.RSTn		(RSTn),
		.prog_i		(prog),
		.run_i		(run),
		.tohost_we_o	(tohost_we),
		.tohost_o	(tohost)
	);

	always #2 CLK = ~CLK;	// 4 ns period

	task automatic compare(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic reset_dut();
		@(negedge CLK);
		RSTn = 1'b0;
		run  = 1'b0;
		prog = '0;
		repeat (3) @(negedge CLK);
		RSTn = 1'b1;
	endtask

	task automatic load_program(input int p);
		for (int i = 0; i < prog_len[p]; i++) begin
			@(negedge CLK);
			prog.valid = 1'b1;
			prog.addr  = i[`ISS_MEM_AW-1:0];
			prog.data  = prog_words[p][i];
		end
		@(negedge CLK);
		prog = '0;
	endtask

	// Strobe is sampled at the falling edge, half a cycle after it rose
	task automatic wait_mailbox(output bit seen);
		int cyc;
		seen = 1'b0;
		cyc  = 0;
		while (!seen && cyc < TIMEOUT_CYCLES) begin
			@(negedge CLK);
			if (tohost_we) begin
				seen = 1'b1;
			end
			cyc++;
		end
	endtask

	initial begin
		bit seen;

		CLK    = 1'b0;
		RSTn   = 1'b0;
		run    = 1'b0;
		prog   = '0;
		errors = 0;
		checks = 0;
		void'($urandom(32'hc875));
		build_programs();

		for (int p = 0; p < prog_count; p++) begin
			reset_dut();
			load_program(p);
			run = 1'b1;
			wait_mailbox(seen);
			if (seen) begin
				compare($sformatf("tohost_o (program %0d)", p),
					tohost & prog_mask[p], prog_exp[p] & prog_mask[p]);
				@(negedge CLK);
				// Self loop stores nothing more, so the strobe must drop
				compare($sformatf("tohost_we_o (program %0d)", p),
					{63'd0, tohost_we}, 64'd0);
			end else begin
				errors++;
				$display("Program %0d never wrote the mailbox within %0d cycles",
					p, TIMEOUT_CYCLES);
			end
			run = 1'b0;
		end

		$display("Programs run: %0d, checks: %0d, errors: %0d", prog_count, checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- tb.f
+incdir+common
+incdir+verif
common/iss_pkg.sv
core/iss_decode.sv
core/iss_alu.sv
core/iss_next_pc.sv
core/iss_core.sv
rtl/iss_mem.sv
rtl/iss_top.sv
verif/tb_iss.sv

//--- run.sh
#!/bin/sh
# Builds and runs the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_iss -o tb_iss_sim
./obj_dir/tb_iss_sim 2>&1 | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
echo "Simulation finished without failure"
exit 0
